// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= datapathTb
FLIST     ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= sim passed
VFLAGS    ?= --binary --assert

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard design/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	grep -qx '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/alu.sv ====
`include "datapath_defines.svh"

module alu (
    input  logic [`DATA_WIDTH-1:0]   yValue,
    input  logic [`DATA_WIDTH-1:0]   busValue,
    input  datapathPkg::aluOp        opcode,
    output logic [2*`DATA_WIDTH-1:0] result
);

    logic [`SHAMT_WIDTH-1:0]          shamt;
    logic [2*`DATA_WIDTH-1:0]         yTwice;
    logic [2*`DATA_WIDTH-1:0]         rolWide;
    logic [2*`DATA_WIDTH-1:0]         rorWide;
    logic signed [2*`DATA_WIDTH-1:0]  product;
    logic [`DATA_WIDTH-1:0]           lowResult;
    logic [`DATA_WIDTH-1:0]           highResult;

    assign shamt   = busValue[`SHAMT_WIDTH-1:0];
    assign yTwice  = {yValue, yValue};  // rotate by shifting a doubled copy
    assign rolWide = yTwice << shamt;
    assign rorWide = yTwice >> shamt;
    assign product = $signed(yValue) * $signed(busValue);

    always_comb begin
        lowResult = '0;
        case (opcode)
            datapathPkg::opAdd: lowResult = yValue + busValue;
            datapathPkg::opSub: lowResult = yValue - busValue;
            datapathPkg::opAnd: lowResult = yValue & busValue;
            datapathPkg::opOr:  lowResult = yValue | busValue;
            datapathPkg::opShr: lowResult = yValue >> shamt;  // logical
            datapathPkg::opShl: lowResult = yValue << shamt;
            datapathPkg::opRor: lowResult = rorWide[`DATA_WIDTH-1:0];
            datapathPkg::opRol: lowResult = rolWide[2*`DATA_WIDTH-1:`DATA_WIDTH];
            datapathPkg::opMul: lowResult = product[`DATA_WIDTH-1:0];
            datapathPkg::opNeg: lowResult = -busValue;
            datapathPkg::opNot: lowResult = ~busValue;
            default:            lowResult = '0;
        endcase
    end

    // only the multiply fills the upper half
    assign highResult = (opcode == datapathPkg::opMul) ?
                        product[2*`DATA_WIDTH-1:`DATA_WIDTH] : '0;

    assign result = {highResult, lowResult};

endmodule

// ==== design/busMux.sv ====
`include "datapath_defines.svh"

module busMux (
    input  datapathPkg::busDrive   drive,
    input  logic [`DATA_WIDTH-1:0] regValue,
    input  logic [`DATA_WIDTH-1:0] pcValue,
    input  logic [`DATA_WIDTH-1:0] zHigh,
    input  logic [`DATA_WIDTH-1:0] zLow,
    input  logic [`DATA_WIDTH-1:0] mdrValue,
    input  logic [`DATA_WIDTH-1:0] hiValue,
    input  logic [`DATA_WIDTH-1:0] loValue,
    input  logic [`DATA_WIDTH-1:0] irConst,
    input  logic [`DATA_WIDTH-1:0] inPort,
    output logic [`DATA_WIDTH-1:0] busValue
);

    logic regDrive;

    assign regDrive = |drive.regOut;  // any general register on the bus

    // AND-OR select, a single strobe passes its source
    assign busValue = ({`DATA_WIDTH{regDrive}}        & regValue)
                    | ({`DATA_WIDTH{drive.pcOut}}     & pcValue)
                    | ({`DATA_WIDTH{drive.zHighOut}}  & zHigh)
                    | ({`DATA_WIDTH{drive.zLowOut}}   & zLow)
                    | ({`DATA_WIDTH{drive.mdrOut}}    & mdrValue)
                    | ({`DATA_WIDTH{drive.hiOut}}     & hiValue)
                    | ({`DATA_WIDTH{drive.loOut}}     & loValue)
                    | ({`DATA_WIDTH{drive.cOut}}      & irConst)
                    | ({`DATA_WIDTH{drive.inPortOut}} & inPort);

endmodule

// ==== design/datapath.sv ====
`include "datapath_defines.svh"

module Datapath (
    input  logic                   Clock,
    input  logic                   rstN,
    input  datapathPkg::ctrlWord   ctrl,
    input  logic [`DATA_WIDTH-1:0] Mdatain,
    input  logic [`DATA_WIDTH-1:0] inPort,
    output logic [`DATA_WIDTH-1:0] busValue,
    output logic [`DATA_WIDTH-1:0] marValue
);

    logic [`DATA_WIDTH-1:0]   regValue;
    logic [`DATA_WIDTH-1:0]   pcValue;
    logic [`DATA_WIDTH-1:0]   irConst;
    logic [`DATA_WIDTH-1:0]   yValue;
    logic [`DATA_WIDTH-1:0]   zHigh;
    logic [`DATA_WIDTH-1:0]   zLow;
    logic [`DATA_WIDTH-1:0]   hiValue;
    logic [`DATA_WIDTH-1:0]   loValue;
    logic [`DATA_WIDTH-1:0]   mdrValue;
    logic [2*`DATA_WIDTH-1:0] aluResult;

    regFile i_regFile (
        .Clock     (Clock),
        .rstN      (rstN),
        .busValue  (busValue),
        .regEnable (ctrl.load.regEnable),
        .regOut    (ctrl.drive.regOut),
        .regValue  (regValue)
    );

    systemRegs i_systemRegs (
        .Clock     (Clock),
        .rstN      (rstN),
        .busValue  (busValue),
        .load      (ctrl.load),
        .aluResult (aluResult),
        .pcValue   (pcValue),
        .irConst   (irConst),
        .yValue    (yValue),
        .zHigh     (zHigh),
        .zLow      (zLow),
        .hiValue   (hiValue),
        .loValue   (loValue),
        .marValue  (marValue)
    );

    memDataReg i_memDataReg (
        .Clock     (Clock),
        .rstN      (rstN),
        .busValue  (busValue),
        .Mdatain   (Mdatain),
        .read      (ctrl.load.read),
        .mdrEnable (ctrl.load.mdrEnable),
        .mdrValue  (mdrValue)
    );

    busMux i_busMux (
        .drive     (ctrl.drive),
        .regValue  (regValue),
        .pcValue   (pcValue),
        .zHigh     (zHigh),
        .zLow      (zLow),
        .mdrValue  (mdrValue),
        .hiValue   (hiValue),
        .loValue   (loValue),
        .irConst   (irConst),
        .inPort    (inPort),
        .busValue  (busValue)
    );

    alu i_alu (
        .yValue    (yValue),
        .busValue  (busValue),
        .opcode    (ctrl.opcode),
        .result    (aluResult)
    );

endmodule

// ==== design/datapathPkg.sv ====
`include "datapath_defines.svh"

package datapathPkg;

    typedef enum logic [4:0] {
        opAdd = 5'b00011,
        opSub = 5'b00100,
        opShr = 5'b00101,
        opShl = 5'b00110,
        opRor = 5'b00111,
        opRol = 5'b01000,
        opAnd = 5'b01001,
        opOr  = 5'b01010,
        opMul = 5'b01110,
        opNeg = 5'b10000,
        opNot = 5'b10001
    } aluOp;

    // bus drive strobes, at most one high per cycle
    typedef struct packed {
        logic                  pcOut;
        logic                  zHighOut;
        logic                  zLowOut;
        logic                  mdrOut;
        logic                  hiOut;
        logic                  loOut;
        logic                  cOut;
        logic                  inPortOut;
        logic [`REG_COUNT-1:0] regOut;    // one bit per general register
    } busDrive;

    typedef struct packed {
        logic                  pcEnable;
        logic                  irEnable;
        logic                  marEnable;
        logic                  yEnable;
        logic                  zEnable;
        logic                  hiEnable;
        logic                  loEnable;
        logic                  mdrEnable;
        logic [`REG_COUNT-1:0] regEnable;
        logic                  incPc;     // PC takes PC+1 instead of the bus
        logic                  read;      // MDR takes Mdatain instead of the bus
    } regLoad;

    // full control input for one step
    typedef struct packed {
        busDrive drive;
        regLoad  load;
        aluOp    opcode;
    } ctrlWord;

endpackage

// ==== design/datapath_defines.svh ====
`ifndef DATAPATH_DEFINES_SVH
`define DATAPATH_DEFINES_SVH

// width of the bus and of every register
`define DATA_WIDTH 32

// number of general registers R0 to R15
`define REG_COUNT 16

// bus bits taken as shift or rotate amount
`define SHAMT_WIDTH 5

`endif

// ==== design/memDataReg.sv ====
`include "datapath_defines.svh"

module memDataReg (
    input  logic                   Clock,
    input  logic                   rstN,
    input  logic [`DATA_WIDTH-1:0] busValue,
    input  logic [`DATA_WIDTH-1:0] Mdatain,
    input  logic                   read,
    input  logic                   mdrEnable,
    output logic [`DATA_WIDTH-1:0] mdrValue
);

    logic [`DATA_WIDTH-1:0] mdrIn;

    assign mdrIn = read ? Mdatain : busValue;  // memory side wins on read

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            mdrValue <= '0;
        end else if (mdrEnable) begin
            mdrValue <= mdrIn;
        end
    end

endmodule

// ==== design/regFile.sv ====
`include "datapath_defines.svh"

module regFile (
    input  logic                   Clock,
    input  logic                   rstN,
    input  logic [`DATA_WIDTH-1:0] busValue,
    input  logic [`REG_COUNT-1:0]  regEnable,
    input  logic [`REG_COUNT-1:0]  regOut,
    output logic [`DATA_WIDTH-1:0] regValue
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                if (regEnable[i]) begin
                    regs[i] <= busValue;
                end
            end
        end
    end

    // one-hot select, zero when no bit set
    always_comb begin
        regValue = '0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            regValue = regValue | ({`DATA_WIDTH{regOut[i]}} & regs[i]);
        end
    end

endmodule

// ==== design/systemRegs.sv ====
`include "datapath_defines.svh"

module systemRegs (
    input  logic                     Clock,
    input  logic                     rstN,
    input  logic [`DATA_WIDTH-1:0]   busValue,
    input  datapathPkg::regLoad      load,
    input  logic [2*`DATA_WIDTH-1:0] aluResult,
    output logic [`DATA_WIDTH-1:0]   pcValue,
    output logic [`DATA_WIDTH-1:0]   irConst,
    output logic [`DATA_WIDTH-1:0]   yValue,
    output logic [`DATA_WIDTH-1:0]   zHigh,
    output logic [`DATA_WIDTH-1:0]   zLow,
    output logic [`DATA_WIDTH-1:0]   hiValue,
    output logic [`DATA_WIDTH-1:0]   loValue,
    output logic [`DATA_WIDTH-1:0]   marValue
);

    localparam int ConstWidth = 19;  // immediate field of the IR

    logic [`DATA_WIDTH-1:0] irValue;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pcValue  <= '0;
            irValue  <= '0;
            marValue <= '0;
            yValue   <= '0;
            zHigh    <= '0;
            zLow     <= '0;
            hiValue  <= '0;
            loValue  <= '0;
        end else begin
            if (load.pcEnable) begin
                pcValue <= load.incPc ? pcValue + 1'b1 : busValue;
            end
            if (load.irEnable)  irValue  <= busValue;
            if (load.marEnable) marValue <= busValue;
            if (load.yEnable)   yValue   <= busValue;
            if (load.hiEnable)  hiValue  <= busValue;
            if (load.loEnable)  loValue  <= busValue;
            if (load.zEnable) begin
                zHigh <= aluResult[2*`DATA_WIDTH-1:`DATA_WIDTH];
                zLow  <= aluResult[`DATA_WIDTH-1:0];
            end
        end
    end

    assign irConst = {{(`DATA_WIDTH-ConstWidth){irValue[ConstWidth-1]}},
                      irValue[ConstWidth-1:0]};  // sign extended C

endmodule

// ==== files.f ====
+incdir+design
design/datapathPkg.sv
design/regFile.sv
design/systemRegs.sv
design/memDataReg.sv
design/busMux.sv
design/alu.sv
design/datapath.sv
verif/datapath_chk.sv
verif/datapath_tb.sv

// ==== verif/datapath_chk.sv ====
`include "datapath_defines.svh"

module datapathChk (
    input logic                   Clock,
    input logic                   rstN,
    input datapathPkg::ctrlWord   ctrl,
    input logic [`DATA_WIDTH-1:0] marValue
);

    // counts every drive strobe, regOut bits included
    oneBusDriver: assert property (@(posedge Clock) disable iff (!rstN)
        $countones(ctrl.drive) <= 1)
        else $error("more than one source drives the bus");

    incOnlyWithPcLoad: assert property (@(posedge Clock) disable iff (!rstN)
        ctrl.load.incPc |-> ctrl.load.pcEnable)
        else $error("incPc high without pcEnable");

    marClearInReset: assert property (@(posedge Clock)
        !rstN |-> marValue == '0)
        else $error("MAR not zero while reset is held");

endmodule

// ==== verif/datapath_tb.sv ====
`include "datapath_defines.svh"

module datapathTb;

    localparam int ResetCycles = 4;
    // steps of the five tests, each closed by one idle step
    localparam int TestSteps = (3 + `REG_COUNT + 1) + (3 * `REG_COUNT + 1)
                             + (11 * 8 + 1) + 9 + 10;
    localparam int CycleLimit = ResetCycles + TestSteps + 20;

    logic                   Clock;
    logic                   rstN;
    datapathPkg::ctrlWord   ctrl;
    logic [`DATA_WIDTH-1:0] Mdatain;
    logic [`DATA_WIDTH-1:0] inPort;
    logic [`DATA_WIDTH-1:0] busValue;
    logic [`DATA_WIDTH-1:0] marValue;

    logic [`DATA_WIDTH-1:0] expQ[$];  // expected bus values in step order
    string                  nameQ[$];
    bit                     sampleBus;
    int                     cycleCount;
    int                     checkCount;
    int                     errorCount;
    int                     testStartErrors;
    int                     testsPassed;
    int                     testsFailed;

    Datapath i_Datapath (
        .Clock    (Clock),
        .rstN     (rstN),
        .ctrl     (ctrl),
        .Mdatain  (Mdatain),
        .inPort   (inPort),
        .busValue (busValue),
        .marValue (marValue)
    );

    bind Datapath datapathChk i_datapathChk (
        .Clock    (Clock),
        .rstN     (rstN),
        .ctrl     (ctrl),
        .marValue (marValue)
    );

    initial begin
        Clock = 1'b0;
        forever #50 Clock = ~Clock;
    end

    // expected 64-bit Z for one ALU operation
    function automatic logic [2*`DATA_WIDTH-1:0] aluModel(datapathPkg::aluOp op,
            logic [`DATA_WIDTH-1:0] y, logic [`DATA_WIDTH-1:0] b);
        logic signed [2*`DATA_WIDTH-1:0] ys;
        logic signed [2*`DATA_WIDTH-1:0] bs;
        logic [`DATA_WIDTH-1:0]          lo;
        int                              s;
        ys = {{`DATA_WIDTH{y[`DATA_WIDTH-1]}}, y};
        bs = {{`DATA_WIDTH{b[`DATA_WIDTH-1]}}, b};
        s  = int'(b[`SHAMT_WIDTH-1:0]);
        if (op == datapathPkg::opMul) begin
            return ys * bs;
        end
        lo = '0;
        case (op)
            datapathPkg::opAdd: lo = y + b;
            datapathPkg::opSub: lo = y - b;
            datapathPkg::opAnd: lo = y & b;
            datapathPkg::opOr:  lo = y | b;
            datapathPkg::opShr: lo = y >> s;
            datapathPkg::opShl: lo = y << s;
            datapathPkg::opRor: lo = (y >> s) | (y << (`DATA_WIDTH - s));
            datapathPkg::opRol: lo = (y << s) | (y >> (`DATA_WIDTH - s));
            datapathPkg::opNeg: lo = ~b + 1'b1;  // two's complement
            datapathPkg::opNot: lo = ~b;
            default:            lo = '0;
        endcase
        return {{`DATA_WIDTH{1'b0}}, lo};
    endfunction

    function automatic datapathPkg::ctrlWord idleCtrl();
        datapathPkg::ctrlWord c;
        c = '0;
        c.opcode = datapathPkg::opAdd;
        return c;
    endfunction

    task automatic checkValue(string name, logic [`DATA_WIDTH-1:0] got,
            logic [`DATA_WIDTH-1:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("FAIL t=%0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic step(datapathPkg::ctrlWord c);
        @(negedge Clock);
        ctrl = c;
        sampleBus = 1'b0;
    endtask

    // one step whose bus value is compared at the next rising edge
    task automatic readBus(datapathPkg::ctrlWord c, logic [`DATA_WIDTH-1:0] exp,
            string name);
        @(negedge Clock);
        ctrl = c;
        sampleBus = 1'b1;
        expQ.push_back(exp);
        nameQ.push_back(name);
    endtask

    // Mdatain into MDR, then MDR into the target register
    task automatic loadReg(int idx, logic [`DATA_WIDTH-1:0] value);
        datapathPkg::ctrlWord c;
        c = idleCtrl();
        c.load.read = 1'b1;
        c.load.mdrEnable = 1'b1;
        step(c);
        Mdatain = value;
        c = idleCtrl();
        c.drive.mdrOut = 1'b1;
        c.load.regEnable[idx] = 1'b1;
        step(c);
    endtask

    task automatic endTest(string name);
        step(idleCtrl());
        if (expQ.size() != 0) begin
            $display("ERROR: %0d bus reads in %s were never compared", expQ.size(), name);
            errorCount++;
            expQ.delete();
            nameQ.delete();
        end
        if (errorCount == testStartErrors) begin
            testsPassed++;
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: %0d errors", name, errorCount - testStartErrors);
        end
        testStartErrors = errorCount;
    endtask

    always @(posedge Clock) begin
        if (sampleBus) begin
            if (expQ.size() == 0) begin
                $display("ERROR: bus sampled with no expected value queued");
                errorCount++;
            end else begin
                checkValue(nameQ.pop_front(), busValue, expQ.pop_front());
            end
        end
    end

    always @(posedge Clock) begin
        cycleCount++;
        if (cycleCount > CycleLimit) begin
            $display("timeout: run went past %0d cycles", CycleLimit);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        datapathPkg::ctrlWord   c;
        datapathPkg::aluOp      op;
        logic [`DATA_WIDTH-1:0] regVals [`REG_COUNT];
        logic [`DATA_WIDTH-1:0] a;
        logic [`DATA_WIDTH-1:0] b;
        logic [2*`DATA_WIDTH-1:0] expZ;
        void'($urandom(32'h1eac91ec));
        ctrl = idleCtrl();
        Mdatain = '0;
        inPort = '0;
        sampleBus = 1'b0;
        rstN = 1'b1;
        #1 rstN = 1'b0;
        repeat (ResetCycles) @(posedge Clock);
        @(negedge Clock);
        rstN = 1'b1;

        c = idleCtrl();
        readBus(c, '0, "bus idle");
        c.drive.pcOut = 1'b1;
        readBus(c, '0, "pcOut");
        c = idleCtrl();
        c.drive.mdrOut = 1'b1;
        readBus(c, '0, "mdrOut");
        for (int i = 0; i < `REG_COUNT; i++) begin
            c = idleCtrl();
            c.drive.regOut[i] = 1'b1;
            readBus(c, '0, $sformatf("R%0d after reset", i));
        end
        endTest("reset");

        for (int i = 0; i < `REG_COUNT; i++) begin
            regVals[i] = $urandom;
            loadReg(i, regVals[i]);
        end
        for (int i = 0; i < `REG_COUNT; i++) begin
            c = idleCtrl();
            c.drive.regOut[i] = 1'b1;
            readBus(c, regVals[i], $sformatf("R%0d", i));
        end
        endTest("register load");

        op = op.first();
        repeat (op.num()) begin
            a = $urandom;
            b = $urandom;
            expZ = aluModel(op, a, b);
            loadReg(2, a);
            loadReg(3, b);
            c = idleCtrl();
            c.drive.regOut[2] = 1'b1;
            c.load.yEnable = 1'b1;
            step(c);
            c = idleCtrl();
            c.drive.regOut[3] = 1'b1;
            c.load.zEnable = 1'b1;
            c.opcode = op;
            step(c);
            c = idleCtrl();
            c.drive.zLowOut = 1'b1;
            readBus(c, expZ[`DATA_WIDTH-1:0], $sformatf("zLow %s", op.name()));
            c = idleCtrl();
            c.drive.zHighOut = 1'b1;
            readBus(c, expZ[2*`DATA_WIDTH-1:`DATA_WIDTH], $sformatf("zHigh %s", op.name()));
            op = op.next();
        end
        endTest("alu");

        a = $urandom;  // start PC
        b = $urandom;  // fetched word
        loadReg(1, a);
        c = idleCtrl();
        c.drive.regOut[1] = 1'b1;
        c.load.pcEnable = 1'b1;
        step(c);
        c = idleCtrl();
        c.drive.pcOut = 1'b1;
        c.load.marEnable = 1'b1;
        c.load.incPc = 1'b1;
        c.load.pcEnable = 1'b1;
        step(c);
        c = idleCtrl();
        c.load.read = 1'b1;
        c.load.mdrEnable = 1'b1;
        step(c);
        Mdatain = b;
        checkValue("marValue", marValue, a);
        c = idleCtrl();
        c.drive.mdrOut = 1'b1;
        c.load.irEnable = 1'b1;
        step(c);
        c = idleCtrl();
        c.drive.pcOut = 1'b1;
        readBus(c, a + 32'd1, "pc after fetch");
        c = idleCtrl();
        c.drive.cOut = 1'b1;
        readBus(c, {{13{b[18]}}, b[18:0]}, "cOut");
        endTest("fetch");

        a = $urandom;
        b = $urandom;  // input port value
        loadReg(5, a);
        loadReg(6, ~a);  // MDR and Mdatain now hold something other than a
        c = idleCtrl();
        c.drive.regOut[5] = 1'b1;
        c.load.mdrEnable = 1'b1;
        c.load.hiEnable = 1'b1;
        c.load.loEnable = 1'b1;
        step(c);
        c = idleCtrl();
        c.drive.mdrOut = 1'b1;
        readBus(c, a, "mdrOut from bus");
        c = idleCtrl();
        c.drive.hiOut = 1'b1;
        readBus(c, a, "hiOut");
        c = idleCtrl();
        c.drive.loOut = 1'b1;
        readBus(c, a, "loOut");
        inPort = b;
        c = idleCtrl();
        c.drive.inPortOut = 1'b1;
        readBus(c, b, "inPortOut");
        endTest("mdr hi lo inport");

        $display("tests passed %0d failed %0d, checks %0d, mismatches %0d",
                 testsPassed, testsFailed, checkCount, errorCount);
        if (errorCount == 0 && testsFailed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
